// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_rvfi_mon
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
rtl/rvfi_mon_pkg.sv
rtl/rvfi_cause_check.sv
rtl/rvfi_mem_check.sv
rtl/rvfi_retire_check.sv
rtl/rvfi_err_log.sv
rtl/rvfi_mon_top.sv
tests/tb_rvfi_mon.sv

// File: rtl/rvfi_cause_check.sv
`timescale 1ns/1ps

module rvfi_cause_check #(
  parameter bit CLIC          = 1'b0,
  parameter int CLIC_ID_WIDTH = 5
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 rvfi_valid,
  input  logic [rvfi_mon_pkg::DBG_CAUSE_W-1:0] rvfi_dbg,
  input  logic                                 rvfi_dbg_mode,
  input  logic [rvfi_mon_pkg::XLEN-1:0]        rvfi_csr_dcsr_rdata,
  input  logic [rvfi_mon_pkg::XLEN-1:0]        rvfi_csr_mcause_wdata,
  input  logic [rvfi_mon_pkg::XLEN-1:0]        rvfi_csr_mcause_wmask,
  input  logic                                 trap_exception,
  input  logic [5:0]                           trap_exception_cause,
  input  logic                                 trap_debug,
  input  logic [rvfi_mon_pkg::DBG_CAUSE_W-1:0] trap_debug_cause,
  input  logic                                 intr_interrupt,
  input  logic                                 intr_exception,
  input  logic [rvfi_mon_pkg::CAUSE_W-1:0]     intr_cause,
  output logic [rvfi_mon_pkg::NUM_CHECKS-1:0]  viol
);

  import rvfi_mon_pkg::*;

  localparam int unsigned MAX_CLIC_ID = (1 << CLIC_ID_WIDTH) - 1;

  logic               was_dbg_mode;
  logic               was_exception;
  dbg_cause_e         dcsr_cause;
  logic [CAUSE_W-1:0] mcause_exccode;
  logic               exc_outside_dbg;
  logic               irq_cause_legal;
  logic               nmi_cause;

  // History of the previous retirement only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      was_dbg_mode  <= 1'b0;
      was_exception <= 1'b0;
    end else if (rvfi_valid) begin
      was_dbg_mode  <= rvfi_dbg_mode;
      was_exception <= trap_exception;
    end
  end

  assign dcsr_cause      = dbg_cause_e'(rvfi_csr_dcsr_rdata[DCSR_CAUSE_LSB +: DBG_CAUSE_W]);
  assign mcause_exccode  = CAUSE_W'(rvfi_csr_mcause_wdata & rvfi_csr_mcause_wmask);
  assign exc_outside_dbg = rvfi_valid && trap_exception && !rvfi_dbg_mode;
  assign nmi_cause       = (intr_cause >= NMI_CAUSE_LO) && (intr_cause <= NMI_CAUSE_HI);

  // Legal cause set depends on the interrupt controller
  always_comb begin
    if (CLIC) begin
      irq_cause_legal = (32'(intr_cause) <= MAX_CLIC_ID) || nmi_cause;
    end else begin
      irq_cause_legal = (intr_cause == CLINT_IRQ_MSI) ||
                        (intr_cause == CLINT_IRQ_MTI) ||
                        (intr_cause == CLINT_IRQ_MEI) ||
                        ((intr_cause >= CLINT_IRQ_HI_BASE) &&
                         (intr_cause <= CLINT_IRQ_HI_LAST)) ||
                        nmi_cause;
    end
  end

  always_comb begin
    viol = '0;

    // Only checked on entry, not while already halted
    viol[CHK_DBG_CAUSE - 1] = rvfi_valid && (rvfi_dbg != DBG_NONE) && !was_dbg_mode &&
                              (rvfi_dbg != dcsr_cause);

    viol[CHK_EXC_CAUSE - 1] = exc_outside_dbg &&
                              (CAUSE_W'(trap_exception_cause) != mcause_exccode);

    // Exception must write mcause.interrupt as zero
    viol[CHK_EXC_MCAUSE_IRQ - 1] = exc_outside_dbg &&
                                   !(rvfi_csr_mcause_wmask[MCAUSE_IRQ_BIT] &&
                                     !rvfi_csr_mcause_wdata[MCAUSE_IRQ_BIT]);

    viol[CHK_IRQ_LEGAL - 1] = rvfi_valid && intr_interrupt && !irq_cause_legal;

    // CLIC allows interrupt id zero
    viol[CHK_CAUSE_NONZERO - 1] = rvfi_valid &&
                                  ((trap_exception && (trap_exception_cause == '0)) ||
                                   (trap_debug && (trap_debug_cause == '0)) ||
                                   (!CLIC && intr_interrupt && (intr_cause == '0)));

    // Sync handler entry mirrors the previous exception
    viol[CHK_SYNC_CAUSE - 1] = rvfi_valid && !intr_interrupt &&
                               (intr_exception != was_exception);

    viol[CHK_HANDLER_AMBIG - 1] = rvfi_valid && intr_exception && intr_interrupt;
  end

endmodule

// File: rtl/rvfi_err_log.sv
`timescale 1ns/1ps

module rvfi_err_log (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [rvfi_mon_pkg::NUM_CHECKS-1:0] viol,
  output logic [rvfi_mon_pkg::NUM_CHECKS-1:0] err_flags,
  output logic [rvfi_mon_pkg::CNT_W-1:0]      err_count,
  output rvfi_mon_pkg::chk_id_e               first_err,
  output logic                                first_err_valid
);

  import rvfi_mon_pkg::*;

  logic [CNT_W-1:0] viol_num;
  logic [CNT_W:0]   count_sum;
  logic [CNT_W-1:0] count_next;
  chk_id_e          lowest_id;

  // Number of checks violated this cycle
  always_comb begin
    viol_num = '0;
    for (int i = 0; i < NUM_CHECKS; i++) begin
      viol_num = viol_num + CNT_W'(viol[i]);
    end
  end

  // Extra carry bit detects overflow for saturation
  assign count_sum  = {1'b0, err_count} + {1'b0, viol_num};
  assign count_next = count_sum[CNT_W] ? '1 : count_sum[CNT_W-1:0];

  // Scan downwards so the lowest set bit wins
  always_comb begin
    lowest_id = CHK_NONE;
    for (int i = NUM_CHECKS - 1; i >= 0; i--) begin
      if (viol[i]) begin
        lowest_id = chk_id_e'(4'(i + 1));
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_flags <= '0;
      err_count <= '0;
    end else begin
      err_flags <= err_flags | viol;
      err_count <= count_next;
    end
  end

  // Only the first failing cycle is captured
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_err       <= CHK_NONE;
      first_err_valid <= 1'b0;
    end else if (!first_err_valid && (|viol)) begin
      first_err       <= lowest_id;
      first_err_valid <= 1'b1;
    end
  end

endmodule

// File: rtl/rvfi_mem_check.sv
`timescale 1ns/1ps

module rvfi_mem_check (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                rvfi_valid,
  input  logic [rvfi_mon_pkg::MASK_W-1:0]     rvfi_mem_rmask,
  input  logic [rvfi_mon_pkg::MASK_W-1:0]     rvfi_mem_wmask,
  input  logic                                rvfi_trap,
  input  logic                                is_load_instr,
  input  logic                                is_store_instr,
  input  logic                                is_load_acc_fault,
  input  logic                                is_store_acc_fault,
  input  logic                                bus_valid,
  input  logic                                bus_ready,
  output logic [rvfi_mon_pkg::NUM_CHECKS-1:0] viol
);

  import rvfi_mon_pkg::*;

  logic             has_rmask;
  logic             has_wmask;
  logic             load_bad;
  logic             store_bad;
  logic [1:0]       mem_new;
  logic [CNT_W-1:0] bus_cnt_q;
  logic [CNT_W-1:0] bus_cnt_d;
  logic [CNT_W-1:0] mem_cnt_q;
  logic [CNT_W-1:0] mem_cnt_d;

  assign has_rmask = |rvfi_mem_rmask;
  assign has_wmask = |rvfi_mem_wmask;

  // Loads own rmask, need one when they retire cleanly, and own load faults
  assign load_bad = (has_rmask && !is_load_instr) ||
                    (is_load_instr && !rvfi_trap && !has_rmask) ||
                    (is_load_acc_fault && !is_load_instr);

  // Same rules for the store side
  assign store_bad = (has_wmask && !is_store_instr) ||
                     (is_store_instr && !rvfi_trap && !has_wmask) ||
                     (is_store_acc_fault && !is_store_instr);

  // Single lane, so at most one read and one write per retirement
  always_comb begin
    mem_new = 2'd0;
    if (rvfi_valid && has_rmask) begin
      mem_new = mem_new + 2'd1;
    end
    if (rvfi_valid && has_wmask) begin
      mem_new = mem_new + 2'd1;
    end
  end

  assign bus_cnt_d = bus_cnt_q + CNT_W'(bus_valid && bus_ready);
  assign mem_cnt_d = mem_cnt_q + CNT_W'(mem_new);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_cnt_q <= '0;
      mem_cnt_q <= '0;
    end else begin
      bus_cnt_q <= bus_cnt_d;
      mem_cnt_q <= mem_cnt_d;
    end
  end

  always_comb begin
    viol = '0;
    viol[CHK_LOAD_MASK - 1]  = rvfi_valid && load_bad;
    viol[CHK_STORE_MASK - 1] = rvfi_valid && store_bad;
    // Handshake in the same cycle as the retirement still covers it
    viol[CHK_MEM_COUNT - 1]  = mem_cnt_d > bus_cnt_d;
  end

endmodule

// File: rtl/rvfi_mon_pkg.sv
package rvfi_mon_pkg;

  // Data path and CSR widths
  localparam int XLEN        = 32;
  localparam int MASK_W      = 4;
  localparam int CAUSE_W     = 11;
  localparam int CNT_W       = 16;
  localparam int DBG_CAUSE_W = 3;
  localparam int NUM_CHECKS  = 12;

  // Field positions inside dcsr and mcause
  localparam int DCSR_CAUSE_LSB = 6;
  localparam int MCAUSE_IRQ_BIT = 31;

  // Check identifiers whose flag bit is the value minus one
  typedef enum logic [3:0] {
    CHK_NONE           = 4'd0,
    CHK_RS_RESET       = 4'd1,
    CHK_DBG_CAUSE      = 4'd2,
    CHK_EXC_CAUSE      = 4'd3,
    CHK_EXC_MCAUSE_IRQ = 4'd4,
    CHK_IRQ_LEGAL      = 4'd5,
    CHK_CAUSE_NONZERO  = 4'd6,
    CHK_SYNC_CAUSE     = 4'd7,
    CHK_HANDLER_AMBIG  = 4'd8,
    CHK_IRQ_COUNT      = 4'd9,
    CHK_MEM_COUNT      = 4'd10,
    CHK_LOAD_MASK      = 4'd11,
    CHK_STORE_MASK     = 4'd12
  } chk_id_e;

  // Debug entry causes as found in dcsr.cause
  typedef enum logic [DBG_CAUSE_W-1:0] {
    DBG_NONE    = 3'd0,
    DBG_EBREAK  = 3'd1,
    DBG_TRIGGER = 3'd2,
    DBG_HALTREQ = 3'd3,
    DBG_STEP    = 3'd4
  } dbg_cause_e;

  // Standard CLINT interrupts
  localparam logic [CAUSE_W-1:0] CLINT_IRQ_MSI = 11'd3;
  localparam logic [CAUSE_W-1:0] CLINT_IRQ_MTI = 11'd7;
  localparam logic [CAUSE_W-1:0] CLINT_IRQ_MEI = 11'd11;

  // Platform fast interrupts
  localparam logic [CAUSE_W-1:0] CLINT_IRQ_HI_BASE = 11'd16;
  localparam logic [CAUSE_W-1:0] CLINT_IRQ_HI_LAST = 11'd31;

  // NMI causes that are legal for both controller styles
  localparam logic [CAUSE_W-1:0] NMI_CAUSE_LO = 11'd1024;
  localparam logic [CAUSE_W-1:0] NMI_CAUSE_HI = 11'd1027;

endpackage

// File: rtl/rvfi_mon_top.sv
`timescale 1ns/1ps

module rvfi_mon_top #(
  parameter bit CLIC          = 1'b0,
  parameter int CLIC_ID_WIDTH = 5
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Retirement record
  input  logic                                 rvfi_valid,
  input  logic [4:0]                           rvfi_rs1_addr,
  input  logic [4:0]                           rvfi_rs2_addr,
  input  logic [rvfi_mon_pkg::XLEN-1:0]        rvfi_rs1_rdata,
  input  logic [rvfi_mon_pkg::XLEN-1:0]        rvfi_rs2_rdata,
  input  logic [rvfi_mon_pkg::DBG_CAUSE_W-1:0] rvfi_dbg,
  input  logic                                 rvfi_dbg_mode,
  input  logic [rvfi_mon_pkg::XLEN-1:0]        rvfi_csr_dcsr_rdata,
  input  logic [rvfi_mon_pkg::XLEN-1:0]        rvfi_csr_mcause_wdata,
  input  logic [rvfi_mon_pkg::XLEN-1:0]        rvfi_csr_mcause_wmask,
  input  logic                                 trap_exception,
  input  logic [5:0]                           trap_exception_cause,
  input  logic                                 trap_debug,
  input  logic [rvfi_mon_pkg::DBG_CAUSE_W-1:0] trap_debug_cause,
  input  logic                                 intr_interrupt,
  input  logic                                 intr_exception,
  input  logic [rvfi_mon_pkg::CAUSE_W-1:0]     intr_cause,
  input  logic                                 rvfi_trap,
  input  logic [rvfi_mon_pkg::MASK_W-1:0]      rvfi_mem_rmask,
  input  logic [rvfi_mon_pkg::MASK_W-1:0]      rvfi_mem_wmask,
  input  logic                                 is_load_instr,
  input  logic                                 is_store_instr,
  input  logic                                 is_load_acc_fault,
  input  logic                                 is_store_acc_fault,
  // Side events
  input  logic                                 bus_valid,
  input  logic                                 bus_ready,
  input  logic                                 irq_ack,
  // Error status
  output logic [rvfi_mon_pkg::NUM_CHECKS-1:0]  err_flags,
  output logic [rvfi_mon_pkg::CNT_W-1:0]       err_count,
  output rvfi_mon_pkg::chk_id_e                first_err,
  output logic                                 first_err_valid
);

  import rvfi_mon_pkg::*;

  logic [NUM_CHECKS-1:0] cause_viol;
  logic [NUM_CHECKS-1:0] mem_viol;
  logic [NUM_CHECKS-1:0] retire_viol;
  logic [NUM_CHECKS-1:0] all_viol;

  rvfi_cause_check #(
    .CLIC          (CLIC),
    .CLIC_ID_WIDTH (CLIC_ID_WIDTH)
  ) i_cause (
    .clk_i, .rst_ni, .rvfi_valid, .rvfi_dbg, .rvfi_dbg_mode, .rvfi_csr_dcsr_rdata,
    .rvfi_csr_mcause_wdata, .rvfi_csr_mcause_wmask, .trap_exception,
    .trap_exception_cause, .trap_debug, .trap_debug_cause, .intr_interrupt,
    .intr_exception, .intr_cause,
    .viol (cause_viol)
  );

  rvfi_mem_check i_mem (
    .clk_i, .rst_ni, .rvfi_valid, .rvfi_mem_rmask, .rvfi_mem_wmask, .rvfi_trap,
    .is_load_instr, .is_store_instr, .is_load_acc_fault, .is_store_acc_fault,
    .bus_valid, .bus_ready,
    .viol (mem_viol)
  );

  rvfi_retire_check i_retire (
    .clk_i, .rst_ni, .rvfi_valid, .rvfi_rs1_addr, .rvfi_rs2_addr, .rvfi_rs1_rdata,
    .rvfi_rs2_rdata, .intr_interrupt, .irq_ack,
    .viol (retire_viol)
  );

  // Checkers own disjoint bits
  assign all_viol = cause_viol | mem_viol | retire_viol;

  rvfi_err_log i_log (
    .clk_i, .rst_ni,
    .viol (all_viol),
    .err_flags, .err_count, .first_err, .first_err_valid
  );

endmodule

// File: rtl/rvfi_retire_check.sv
`timescale 1ns/1ps

module rvfi_retire_check (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                rvfi_valid,
  input  logic [4:0]                          rvfi_rs1_addr,
  input  logic [4:0]                          rvfi_rs2_addr,
  input  logic [rvfi_mon_pkg::XLEN-1:0]       rvfi_rs1_rdata,
  input  logic [rvfi_mon_pkg::XLEN-1:0]       rvfi_rs2_rdata,
  input  logic                                intr_interrupt,
  input  logic                                irq_ack,
  output logic [rvfi_mon_pkg::NUM_CHECKS-1:0] viol
);

  import rvfi_mon_pkg::*;

  logic             first_retire;
  logic             rs1_bad;
  logic             rs2_bad;
  logic [CNT_W-1:0] ack_cnt_q;
  logic [CNT_W-1:0] ack_cnt_d;
  logic [CNT_W-1:0] irq_cnt_q;
  logic [CNT_W-1:0] irq_cnt_d;

  // Set by reset, dropped by the first retirement
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_retire <= 1'b1;
    end else if (rvfi_valid) begin
      first_retire <= 1'b0;
    end
  end

  // x0 reads zero anyway, other registers come out of reset as zero
  assign rs1_bad = (rvfi_rs1_addr != '0) && (rvfi_rs1_rdata != '0);
  assign rs2_bad = (rvfi_rs2_addr != '0) && (rvfi_rs2_rdata != '0);

  assign ack_cnt_d = ack_cnt_q + CNT_W'(irq_ack);
  assign irq_cnt_d = irq_cnt_q + CNT_W'(rvfi_valid && intr_interrupt);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_cnt_q <= '0;
      irq_cnt_q <= '0;
    end else begin
      ack_cnt_q <= ack_cnt_d;
      irq_cnt_q <= irq_cnt_d;
    end
  end

  always_comb begin
    viol = '0;
    viol[CHK_RS_RESET - 1]  = rvfi_valid && first_retire && (rs1_bad || rs2_bad);
    // Every reported interrupt needs an acknowledge at or before it
    viol[CHK_IRQ_COUNT - 1] = irq_cnt_d > ack_cnt_d;
  end

endmodule

// File: tests/tb_rvfi_mon.sv
`timescale 1ns/1ps

module tb_rvfi_mon;

  import rvfi_mon_pkg::*;

  logic clk_i, rst_ni;
  logic rvfi_valid, rvfi_dbg_mode, trap_exception, trap_debug, intr_interrupt, intr_exception;
  logic [4:0] rvfi_rs1_addr, rvfi_rs2_addr;
  logic [XLEN-1:0] rvfi_rs1_rdata, rvfi_rs2_rdata, rvfi_csr_dcsr_rdata;
  logic [XLEN-1:0] rvfi_csr_mcause_wdata, rvfi_csr_mcause_wmask;
  logic [DBG_CAUSE_W-1:0] rvfi_dbg, trap_debug_cause;
  logic [5:0] trap_exception_cause;
  logic [CAUSE_W-1:0] intr_cause;
  logic rvfi_trap, is_load_instr, is_store_instr, is_load_acc_fault, is_store_acc_fault;
  logic [MASK_W-1:0] rvfi_mem_rmask, rvfi_mem_wmask;
  logic bus_valid, bus_ready, irq_ack;
  logic [NUM_CHECKS-1:0] err_flags;
  logic [CNT_W-1:0] err_count;
  chk_id_e first_err;
  logic first_err_valid;

  // Reference model state
  logic m_was_dbg, m_was_exc, m_first;
  int m_bus, m_mem, m_ack, m_irq;
  logic [NUM_CHECKS-1:0] exp_flags, exp_v;
  logic [CNT_W-1:0] exp_count;
  chk_id_e exp_first;
  logic exp_first_valid;
  int sum;
  // Generator state
  logic gen_exc, gen_first;
  int errors = 0;
  string test_name = "init";

  rvfi_mon_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    for (int i = 0; i < 100000; i++) begin
      @(posedge clk_i);
    end
    $display("Timeout: the test sequence did not finish");
    $display("sim failed");
    $finish;
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("ERR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    end
  endtask

  function automatic logic [NUM_CHECKS-1:0] ref_viol();
    logic [NUM_CHECKS-1:0] v;
    logic exc;
    logic legal;
    logic [CAUSE_W-1:0] mc;
    logic [CAUSE_W-1:0] ic;
    int bus_n, mem_n, ack_n, irq_n;
    v = '0;
    ic = intr_cause;
    mc = rvfi_csr_mcause_wdata[CAUSE_W-1:0] & rvfi_csr_mcause_wmask[CAUSE_W-1:0];
    exc = rvfi_valid && trap_exception && !rvfi_dbg_mode;
    legal = (ic == 11'd3) || (ic == 11'd7) || (ic == 11'd11) ||
            (ic >= 11'd16 && ic <= 11'd31) || (ic >= 11'd1024 && ic <= 11'd1027);
    v[CHK_DBG_CAUSE-1] = rvfi_valid && rvfi_dbg != 3'd0 && !m_was_dbg &&
                         rvfi_dbg != rvfi_csr_dcsr_rdata[8:6];
    v[CHK_EXC_CAUSE-1] = exc && ({5'd0, trap_exception_cause} != mc);
    v[CHK_EXC_MCAUSE_IRQ-1] = exc && !(rvfi_csr_mcause_wmask[31] && !rvfi_csr_mcause_wdata[31]);
    v[CHK_IRQ_LEGAL-1] = rvfi_valid && intr_interrupt && !legal;
    v[CHK_CAUSE_NONZERO-1] = rvfi_valid && ((trap_exception && trap_exception_cause == 6'd0) ||
                             (trap_debug && trap_debug_cause == 3'd0) ||
                             (intr_interrupt && ic == 11'd0));
    v[CHK_SYNC_CAUSE-1] = rvfi_valid && !intr_interrupt && (intr_exception != m_was_exc);
    v[CHK_HANDLER_AMBIG-1] = rvfi_valid && intr_exception && intr_interrupt;
    v[CHK_LOAD_MASK-1] = rvfi_valid && ((|rvfi_mem_rmask && !is_load_instr) ||
                         (is_load_instr && !rvfi_trap && rvfi_mem_rmask == 4'd0) ||
                         (is_load_acc_fault && !is_load_instr));
    v[CHK_STORE_MASK-1] = rvfi_valid && ((|rvfi_mem_wmask && !is_store_instr) ||
                          (is_store_instr && !rvfi_trap && rvfi_mem_wmask == 4'd0) ||
                          (is_store_acc_fault && !is_store_instr));
    bus_n = m_bus + int'(bus_valid && bus_ready);
    mem_n = m_mem + int'(rvfi_valid && |rvfi_mem_rmask) + int'(rvfi_valid && |rvfi_mem_wmask);
    v[CHK_MEM_COUNT-1] = mem_n > bus_n;
    v[CHK_RS_RESET-1] = rvfi_valid && m_first &&
                        ((rvfi_rs1_addr != 5'd0 && rvfi_rs1_rdata != 32'd0) ||
                         (rvfi_rs2_addr != 5'd0 && rvfi_rs2_rdata != 32'd0));
    ack_n = m_ack + int'(irq_ack);
    irq_n = m_irq + int'(rvfi_valid && intr_interrupt);
    v[CHK_IRQ_COUNT-1] = irq_n > ack_n;
    return v;
  endfunction

  // Outputs reflect all earlier edges, so compare first and then step the model
  always @(negedge clk_i) begin
    if (rst_ni !== 1'b1) begin
      m_was_dbg = 1'b0;
      m_was_exc = 1'b0;
      m_first = 1'b1;
      m_bus = 0;
      m_mem = 0;
      m_ack = 0;
      m_irq = 0;
      exp_flags = '0;
      exp_count = '0;
      exp_first = CHK_NONE;
      exp_first_valid = 1'b0;
    end else begin
      check_val({test_name, " flags"}, 32'(exp_flags), 32'(err_flags));
      check_val({test_name, " count"}, 32'(exp_count), 32'(err_count));
      check_val({test_name, " first_err"}, 32'(exp_first), 32'(first_err));
      check_val({test_name, " first_valid"}, 32'(exp_first_valid), 32'(first_err_valid));
      exp_v = ref_viol();
      exp_flags = exp_flags | exp_v;
      sum = int'(exp_count) + $countones(exp_v);
      exp_count = (sum > 65535) ? 16'hffff : 16'(sum);
      if (!exp_first_valid && |exp_v) begin
        exp_first_valid = 1'b1;
        for (int i = NUM_CHECKS - 1; i >= 0; i--) begin
          if (exp_v[i]) begin
            exp_first = chk_id_e'(4'(i + 1));
          end
        end
      end
      m_bus += int'(bus_valid && bus_ready);
      m_mem += int'(rvfi_valid && |rvfi_mem_rmask) + int'(rvfi_valid && |rvfi_mem_wmask);
      m_ack += int'(irq_ack);
      m_irq += int'(rvfi_valid && intr_interrupt);
      if (rvfi_valid) begin
        m_was_dbg = rvfi_dbg_mode;
        m_was_exc = trap_exception;
        m_first = 1'b0;
      end
    end
  end

  task automatic set_idle();
    rvfi_valid <= 1'b0;
    rvfi_rs1_addr <= 5'd0;
    rvfi_rs2_addr <= 5'd0;
    rvfi_rs1_rdata <= '0;
    rvfi_rs2_rdata <= '0;
    rvfi_dbg <= 3'd0;
    rvfi_dbg_mode <= 1'b0;
    rvfi_csr_dcsr_rdata <= '0;
    rvfi_csr_mcause_wdata <= '0;
    rvfi_csr_mcause_wmask <= '0;
    trap_exception <= 1'b0;
    trap_exception_cause <= 6'd0;
    trap_debug <= 1'b0;
    trap_debug_cause <= 3'd0;
    intr_interrupt <= 1'b0;
    intr_exception <= 1'b0;
    intr_cause <= '0;
    rvfi_trap <= 1'b0;
    rvfi_mem_rmask <= 4'd0;
    rvfi_mem_wmask <= 4'd0;
    is_load_instr <= 1'b0;
    is_store_instr <= 1'b0;
    is_load_acc_fault <= 1'b0;
    is_store_acc_fault <= 1'b0;
    bus_valid <= 1'b0;
    bus_ready <= 1'b0;
    irq_ack <= 1'b0;
  endtask

  task automatic do_reset();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    set_idle();
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    gen_exc = 1'b0;
    gen_first = 1'b1;
  endtask

  task automatic idle(input logic hs, input logic ack);
    @(posedge clk_i);
    set_idle();
    bus_valid <= hs;
    bus_ready <= hs;
    irq_ack <= ack;
  endtask

  // Plain legal retirement whose fields callers override in the same step
  task automatic begin_retire();
    @(posedge clk_i);
    set_idle();
    rvfi_valid <= 1'b1;
    intr_exception <= gen_exc;
    rvfi_rs1_addr <= 5'($urandom);
    rvfi_rs2_addr <= 5'($urandom);
    rvfi_rs1_rdata <= gen_first ? 32'd0 : $urandom();
    rvfi_rs2_rdata <= gen_first ? 32'd0 : $urandom();
    gen_exc = 1'b0;
    gen_first = 1'b0;
  endtask

  function automatic logic [CAUSE_W-1:0] legal_irq();
    case ($urandom_range(0, 4))
      0: return 11'd3;
      1: return 11'd7;
      2: return 11'd11;
      3: return 11'(16 + $urandom_range(0, 15));
      default: return 11'(1024 + $urandom_range(0, 3));
    endcase
  endfunction

  task automatic legal_op();
    logic [5:0] c;
    logic [2:0] d;
    case ($urandom_range(0, 5))
      0: idle(1'b0, 1'b0);
      1: begin_retire();
      2: begin
        c = 6'($urandom_range(1, 15));
        begin_retire();
        trap_exception <= 1'b1;
        rvfi_trap <= 1'b1;
        trap_exception_cause <= c;
        rvfi_csr_mcause_wdata <= {26'd0, c};
        rvfi_csr_mcause_wmask <= '1;
        gen_exc = 1'b1;
      end
      3: begin
        d = 3'($urandom_range(1, 4));
        begin_retire();
        rvfi_dbg <= d;
        rvfi_dbg_mode <= 1'b1;
        trap_debug <= 1'b1;
        trap_debug_cause <= d;
        rvfi_csr_dcsr_rdata <= {23'd0, d, 6'd0};
      end
      4: begin
        idle(1'b1, 1'b0);
        begin_retire();
        if ($urandom_range(0, 1) == 0) begin
          is_load_instr <= 1'b1;
          rvfi_mem_rmask <= 4'($urandom_range(1, 15));
        end else begin
          is_store_instr <= 1'b1;
          rvfi_mem_wmask <= 4'($urandom_range(1, 15));
        end
      end
      default: begin
        idle(1'b0, 1'b1);
        begin_retire();
        intr_interrupt <= 1'b1;
        intr_exception <= 1'b0;
        intr_cause <= legal_irq();
      end
    endcase
  endtask

  task automatic wait_flag(input chk_id_e id);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!err_flags[id-1] && n < 20) begin
      @(negedge clk_i);
      n++;
    end
    if (!err_flags[id-1]) begin
      errors++;
      $display("%s: flag %0d was never raised", test_name, id);
    end
  endtask

  // Single fault raises only its own flag and one count and is the first error
  task automatic expect_only(input chk_id_e id);
    idle(1'b0, 1'b0);
    idle(1'b0, 1'b0);
    wait_flag(id);
    check_val({test_name, " only flag"}, 32'(1) << (id - 1), 32'(err_flags));
    check_val({test_name, " only count"}, 32'd1, 32'(err_count));
    check_val({test_name, " only first"}, 32'(id), 32'(first_err));
  endtask

  initial begin
    void'($urandom(32'hba8f_c9aa));
    rst_ni <= 1'b0;
    set_idle();
    do_reset();
    test_name = "legal_traffic";
    repeat (2000) legal_op();
    idle(1'b0, 1'b0);
    idle(1'b0, 1'b0);
    @(negedge clk_i);
    check_val("legal_traffic flags", 32'd0, 32'(err_flags));
    check_val("legal_traffic count", 32'd0, 32'(err_count));
    check_val("legal_traffic first_valid", 32'd0, 32'(first_err_valid));

    do_reset();
    test_name = "rs_first_retire";
    begin_retire();
    rvfi_rs1_addr <= 5'd5;
    rvfi_rs1_rdata <= 32'h1234;
    expect_only(CHK_RS_RESET);

    do_reset();
    test_name = "rs_later_retire";
    begin_retire();
    begin_retire();
    rvfi_rs1_addr <= 5'd5;
    rvfi_rs1_rdata <= 32'h1234;
    idle(1'b0, 1'b0);
    idle(1'b0, 1'b0);
    @(negedge clk_i);
    check_val("rs_later_retire flags", 32'd0, 32'(err_flags));

    do_reset();
    test_name = "dbg_cause";
    begin_retire();
    rvfi_dbg <= 3'(DBG_STEP);
    rvfi_dbg_mode <= 1'b1;
    rvfi_csr_dcsr_rdata <= {23'd0, 3'(DBG_HALTREQ), 6'd0};
    expect_only(CHK_DBG_CAUSE);

    do_reset();
    test_name = "exc_cause";
    begin_retire();
    trap_exception <= 1'b1;
    rvfi_trap <= 1'b1;
    trap_exception_cause <= 6'd2;
    rvfi_csr_mcause_wdata <= 32'd3;
    rvfi_csr_mcause_wmask <= '1;
    expect_only(CHK_EXC_CAUSE);

    do_reset();
    test_name = "mcause_irq_bit";
    begin_retire();
    trap_exception <= 1'b1;
    rvfi_trap <= 1'b1;
    trap_exception_cause <= 6'd2;
    rvfi_csr_mcause_wdata <= 32'h8000_0002;
    rvfi_csr_mcause_wmask <= '1;
    expect_only(CHK_EXC_MCAUSE_IRQ);

    do_reset();
    test_name = "irq_illegal";
    idle(1'b0, 1'b1);
    begin_retire();
    intr_interrupt <= 1'b1;
    intr_cause <= 11'd5;
    expect_only(CHK_IRQ_LEGAL);

    do_reset();
    test_name = "debug_cause_zero";
    begin_retire();
    trap_debug <= 1'b1;
    trap_debug_cause <= 3'd0;
    expect_only(CHK_CAUSE_NONZERO);

    do_reset();
    test_name = "sync_no_exception";
    begin_retire();
    intr_exception <= 1'b1;
    expect_only(CHK_SYNC_CAUSE);

    do_reset();
    test_name = "handler_ambig";
    idle(1'b0, 1'b1);
    begin_retire();
    intr_interrupt <= 1'b1;
    intr_exception <= 1'b1;
    intr_cause <= 11'd3;
    expect_only(CHK_HANDLER_AMBIG);

    do_reset();
    test_name = "rmask_no_load";
    begin_retire();
    rvfi_mem_rmask <= 4'hf;
    bus_valid <= 1'b1;
    bus_ready <= 1'b1;
    expect_only(CHK_LOAD_MASK);

    do_reset();
    test_name = "load_fault_on_store";
    begin_retire();
    is_store_instr <= 1'b1;
    rvfi_trap <= 1'b1;
    is_load_acc_fault <= 1'b1;
    expect_only(CHK_LOAD_MASK);

    do_reset();
    test_name = "store_empty_wmask";
    begin_retire();
    is_store_instr <= 1'b1;
    expect_only(CHK_STORE_MASK);

    do_reset();
    test_name = "mem_no_handshake";
    begin_retire();
    is_load_instr <= 1'b1;
    rvfi_mem_rmask <= 4'hf;
    idle(1'b1, 1'b0);
    expect_only(CHK_MEM_COUNT);

    do_reset();
    test_name = "irq_no_ack";
    begin_retire();
    intr_interrupt <= 1'b1;
    intr_cause <= 11'd3;
    idle(1'b0, 1'b1);
    begin_retire();
    rvfi_mem_rmask <= 4'h1;
    bus_valid <= 1'b1;
    bus_ready <= 1'b1;
    idle(1'b0, 1'b0);
    idle(1'b0, 1'b0);
    wait_flag(CHK_LOAD_MASK);
    check_val("irq_no_ack flags", (32'(1) << (CHK_IRQ_COUNT - 1)) |
              (32'(1) << (CHK_LOAD_MASK - 1)), 32'(err_flags));
    check_val("irq_no_ack count", 32'd2, 32'(err_count));
    check_val("irq_no_ack first", 32'(CHK_IRQ_COUNT), 32'(first_err));

    @(negedge clk_i);
    $display("Total errors: %0d", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
